//--- Makefile
# Verilator build and run for the hex character engine testbench

VERILATOR ?= verilator
TOP ?= tb_char_engine
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= sim passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) && echo "PASS: found in $(LOG)" || \
		{ echo "FAIL: pass line missing from $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
src/screen_pkg.sv
src/font_pkg.sv
src/field_sequencer.sv
src/glyph_rom.sv
src/vram_writer.sv
src/char_engine.sv
test/tb_char_engine.sv

//--- src/char_engine.sv
`timescale 1ns/1ps

module char_engine #(
	parameter int NUM_ROWS = 32
) (
	input logic clock25,
	input logic arst_n,
	input logic [31:0] ins_data,
	input logic [31:0] mem_data,
	input logic [31:0] reg_data,
	output screen_pkg::probe_sel_t sel,
	output screen_pkg::vram_addr_t vram_addr,
	output screen_pkg::pixel_row_t vram_data,
	output logic vram_write
);

	font_pkg::char_token_t token;
	logic token_strobe;
	font_pkg::glyph_t glyph;
	logic glyph_strobe;
	screen_pkg::vram_addr_t glyph_base;

	field_sequencer #(
		.NUM_ROWS(NUM_ROWS)
	) field_sequencer_i (
		.clock25(clock25),
		.arst_n(arst_n),
		.ins_data(ins_data),
		.mem_data(mem_data),
		.reg_data(reg_data),
		.sel(sel),
		.token(token),
		.token_strobe(token_strobe)
	);

	glyph_rom glyph_rom_i (
		.clock25(clock25),
		.arst_n(arst_n),
		.token(token),
		.token_strobe(token_strobe),
		.glyph(glyph),
		.glyph_strobe(glyph_strobe),
		.glyph_base(glyph_base)
	);

	vram_writer vram_writer_i (
		.clock25(clock25),
		.arst_n(arst_n),
		.glyph(glyph),
		.glyph_strobe(glyph_strobe),
		.glyph_base(glyph_base),
		.vram_addr(vram_addr),
		.vram_data(vram_data),
		.vram_write(vram_write)
	);

endmodule

//--- src/field_sequencer.sv
`timescale 1ns/1ps

module field_sequencer #(
	parameter int NUM_ROWS = 32
) (
	input logic clock25,
	input logic arst_n,
	input logic [31:0] ins_data,
	input logic [31:0] mem_data,
	input logic [31:0] reg_data,
	output screen_pkg::probe_sel_t sel,
	output font_pkg::char_token_t token,
	output logic token_strobe
);

	localparam int PER_W = $clog2(font_pkg::GLYPH_LINES);
	localparam logic [PER_W-1:0] LAST_PER = PER_W'(font_pkg::GLYPH_LINES - 1);

	typedef enum logic [1:0] {
		SELECT,
		CAPTURE,
		CHARS
	} state_t;

	state_t state_q;
	screen_pkg::field_t field_q;
	screen_pkg::row_index_t row_q;
	logic [2:0] pos_q; // Digit position, 0 is most significant
	logic [PER_W-1:0] per_q; // Cycle within the glyph period
	logic [31:0] word_q;
	logic [2:0] nibble_sel;
	screen_pkg::vram_addr_t char_base;

	// Position of the last digit in a field
	function automatic logic [2:0] last_pos(input screen_pkg::field_t f);
		case (f)
			screen_pkg::IDX_INS, screen_pkg::IDX_MEM, screen_pkg::IDX_REG: last_pos = 3'd1;
			default: last_pos = 3'd7;
		endcase
	endfunction

	function automatic screen_pkg::column_t field_col(input screen_pkg::field_t f);
		case (f)
			screen_pkg::IDX_INS: field_col = 7'd2;
			screen_pkg::INS: field_col = 7'd11;
			screen_pkg::IDX_MEM: field_col = 7'd21;
			screen_pkg::MEM: field_col = 7'd30;
			screen_pkg::IDX_REG: field_col = 7'd40;
			default: field_col = 7'd49;
		endcase
	endfunction

	always_ff @(posedge clock25 or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= SELECT;
			field_q <= screen_pkg::IDX_INS;
			row_q <= '0;
			pos_q <= '0;
			per_q <= '0;
			sel <= '0;
		end else begin
			case (state_q)
				SELECT: begin
					sel <= '{reg_sel: row_q, ins_sel: row_q, mem_sel: row_q};
					state_q <= CAPTURE;
				end
				CAPTURE: begin
					state_q <= CHARS;
				end
				CHARS: begin
					if (per_q == LAST_PER) begin
						per_q <= '0;
						if (pos_q == last_pos(field_q)) begin
							pos_q <= '0;
							state_q <= SELECT;
							if (field_q == screen_pkg::REG) begin
								field_q <= screen_pkg::IDX_INS;
								if (row_q == screen_pkg::row_index_t'(NUM_ROWS - 1))
									row_q <= '0; // Next frame
								else
									row_q <= row_q + 1'b1;
							end else begin
								field_q <= screen_pkg::field_t'(field_q + 1'b1);
							end
						end else begin
							pos_q <= pos_q + 1'b1;
						end
					end else begin
						per_q <= per_q + 1'b1;
					end
				end
				default: state_q <= SELECT;
			endcase
		end
	end

	// Probe word or row index, held for the whole field
	always_ff @(posedge clock25) begin
		if (state_q == CAPTURE) begin
			case (field_q)
				screen_pkg::INS: word_q <= ins_data;
				screen_pkg::MEM: word_q <= mem_data;
				screen_pkg::REG: word_q <= reg_data;
				default: word_q <= 32'(row_q);
			endcase
		end
	end

	assign nibble_sel = last_pos(field_q) - pos_q; // MSB nibble first
	assign char_base = screen_pkg::vram_addr_t'(row_q * screen_pkg::ROW_STRIDE
		+ field_col(field_q) + pos_q);

	assign token_strobe = (state_q == CHARS) && (per_q == '0);
	assign token = '{digit: word_q[4*nibble_sel +: 4], base: char_base};

	a_pos_in_field: assert property (@(posedge clock25) disable iff (!arst_n)
		state_q == CHARS |-> pos_q <= last_pos(field_q))
		else $error("digit position past field width");

	// Matches the writer's rate
	a_token_spacing: assert property (@(posedge clock25) disable iff (!arst_n)
		token_strobe |=> !token_strobe [*(font_pkg::GLYPH_LINES - 1)])
		else $error("token_strobe within one glyph period");

endmodule

//--- src/font_pkg.sv
package font_pkg;

	localparam int GLYPH_LINES = 8; // Lines per glyph

	typedef logic [3:0] hex_digit_t;

	// Line 0 is the top line of the glyph
	typedef screen_pkg::pixel_row_t [0:GLYPH_LINES-1] glyph_t;

	// One character to draw
	typedef struct packed {
		hex_digit_t digit;
		screen_pkg::vram_addr_t base; // Address of glyph line 0
	} char_token_t;

endpackage

//--- src/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
	input logic clock25,
	input logic arst_n,
	input font_pkg::char_token_t token,
	input logic token_strobe,
	output font_pkg::glyph_t glyph,
	output logic glyph_strobe,
	output screen_pkg::vram_addr_t glyph_base
);

	// Hex digit patterns, top line first
	function automatic font_pkg::glyph_t hex_glyph(input font_pkg::hex_digit_t d);
		case (d)
			4'h0: hex_glyph = {8'b00111100, 8'b01000010, 8'b01000010, 8'b01000010,
				8'b01000010, 8'b01000010, 8'b01000010, 8'b00111100};
			4'h1: hex_glyph = {8'b00011000, 8'b00111000, 8'b01111000, 8'b00011000,
				8'b00011000, 8'b00011000, 8'b00011000, 8'b01111110};
			4'h2: hex_glyph = {8'b00111100, 8'b01100110, 8'b01100110, 8'b00001100,
				8'b00011000, 8'b00110000, 8'b01100000, 8'b01111110};
			4'h3: hex_glyph = {8'b01111100, 8'b00000110, 8'b00000110, 8'b01111100,
				8'b00000110, 8'b00000110, 8'b00000110, 8'b01111100};
			4'h4: hex_glyph = {8'b00001110, 8'b00010110, 8'b00100110, 8'b01000110,
				8'b01000110, 8'b01111110, 8'b00000110, 8'b00000110};
			4'h5: hex_glyph = {8'b01111110, 8'b01100000, 8'b01100000, 8'b01111000,
				8'b00001100, 8'b00000110, 8'b00001100, 8'b01111000};
			4'h6: hex_glyph = {8'b00111100, 8'b01000000, 8'b01000000, 8'b01111100,
				8'b01000010, 8'b01000010, 8'b01000010, 8'b00111100};
			4'h7: hex_glyph = {8'b01111110, 8'b00000110, 8'b00000110, 8'b00000110,
				8'b00001100, 8'b00011000, 8'b00110000, 8'b01100000};
			4'h8: hex_glyph = {8'b00111100, 8'b01000010, 8'b01000010, 8'b00111100,
				8'b01000010, 8'b01000010, 8'b01000010, 8'b00111100};
			4'h9: hex_glyph = {8'b00111100, 8'b01000110, 8'b01000110, 8'b01000110,
				8'b00111110, 8'b00000110, 8'b00000110, 8'b00000110};
			4'hA: hex_glyph = {8'b00111100, 8'b01000010, 8'b01000010, 8'b01000010,
				8'b01111110, 8'b01000010, 8'b01000010, 8'b01000010};
			4'hB: hex_glyph = {8'b01111100, 8'b01000010, 8'b01000010, 8'b01111100,
				8'b01000110, 8'b01000010, 8'b01000110, 8'b01111100};
			4'hC: hex_glyph = {8'b00111110, 8'b01100000, 8'b01100000, 8'b01100000,
				8'b01100000, 8'b01100000, 8'b01100000, 8'b00111110};
			4'hD: hex_glyph = {8'b01111100, 8'b01100010, 8'b01100010, 8'b01100010,
				8'b01100010, 8'b01100010, 8'b01100010, 8'b01111100};
			4'hE: hex_glyph = {8'b00111110, 8'b01100000, 8'b01100000, 8'b01111110,
				8'b01100000, 8'b01100000, 8'b01100000, 8'b00111110};
			default: hex_glyph = {8'b01111110, 8'b01100000, 8'b01100000, 8'b01111110,
				8'b01100000, 8'b01100000, 8'b01100000, 8'b01100000}; // F
		endcase
	endfunction

	always_ff @(posedge clock25 or negedge arst_n) begin
		if (!arst_n) begin
			glyph_strobe <= 1'b0;
		end else begin
			glyph_strobe <= token_strobe; // One cycle behind the token
		end
	end

	always_ff @(posedge clock25) begin
		if (token_strobe) begin
			glyph <= hex_glyph(token.digit);
			glyph_base <= token.base; // Travels with its glyph
		end
	end

endmodule

//--- src/screen_pkg.sv
package screen_pkg;

	// Character grid of the video memory
	localparam int SCREEN_COLS = 80; // Characters per scan line
	localparam int CELL_LINES = 10; // Glyph on top 8, lines 8 and 9 left blank
	localparam int ROW_STRIDE = SCREEN_COLS * CELL_LINES; // Addresses per character row

	typedef logic [15:0] vram_addr_t; // Byte address into video memory

	typedef logic [7:0] pixel_row_t; // MSB is leftmost pixel, 1 is lit

	typedef logic [4:0] row_index_t; // Display row, also the probe select

	typedef logic [6:0] column_t; // Character column on a scan line

	// Fields of a display row in screen order
	typedef enum logic [2:0] {
		IDX_INS,
		INS,
		IDX_MEM,
		MEM,
		IDX_REG,
		REG
	} field_t;

	// Selects toward the CPU probes
	typedef struct packed {
		row_index_t reg_sel;
		row_index_t ins_sel;
		row_index_t mem_sel;
	} probe_sel_t;

endpackage

//--- src/vram_writer.sv
`timescale 1ns/1ps

module vram_writer (
	input logic clock25,
	input logic arst_n,
	input font_pkg::glyph_t glyph,
	input logic glyph_strobe,
	input screen_pkg::vram_addr_t glyph_base,
	output screen_pkg::vram_addr_t vram_addr,
	output screen_pkg::pixel_row_t vram_data,
	output logic vram_write
);

	localparam int LINE_W = $clog2(font_pkg::GLYPH_LINES);
	localparam logic [LINE_W-1:0] LAST_LINE = LINE_W'(font_pkg::GLYPH_LINES - 1);

	font_pkg::glyph_t glyph_q;
	logic [LINE_W-1:0] line_q; // Next line to write, 0 when idle
	logic busy;

	assign busy = (line_q != '0);

	always_ff @(posedge clock25 or negedge arst_n) begin
		if (!arst_n) begin
			line_q <= '0;
			vram_write <= 1'b0;
		end else begin
			vram_write <= glyph_strobe || busy;
			if (glyph_strobe) begin
				line_q <= LINE_W'(1); // Line 0 goes out now
			end else if (busy) begin
				if (line_q == LAST_LINE)
					line_q <= '0;
				else
					line_q <= line_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clock25) begin
		if (glyph_strobe) begin
			glyph_q <= glyph;
			vram_addr <= glyph_base;
			vram_data <= glyph[0];
		end else if (busy) begin
			vram_addr <= vram_addr + screen_pkg::vram_addr_t'(screen_pkg::SCREEN_COLS);
			vram_data <= glyph_q[line_q];
		end
	end

	// A new glyph may only land once line 7 is on the bus
	a_strobe_when_free: assert property (@(posedge clock25) disable iff (!arst_n)
		glyph_strobe |-> !busy)
		else $error("glyph_strobe while a glyph is still being written");

endmodule

//--- test/tb_char_engine.sv
`timescale 1ns/1ps

module tb_char_engine;

	localparam int NUM_ROWS = 32;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int FIRST_WRITE_CYCLE = 4;
	localparam int WRITES_PER_ROW = 240; // 30 characters of 8 lines
	localparam int WRITES_PER_FRAME = NUM_ROWS * WRITES_PER_ROW;
	localparam int CYCLES_PER_FRAME = 8064;
	localparam int FRAMES = 2;
	localparam int NUM_TESTS = 5;
	localparam int WATCHDOG_NS = FRAMES * CYCLES_PER_FRAME * CLK_PERIOD + 2000;

	typedef struct packed {
		screen_pkg::field_t field;
		screen_pkg::vram_addr_t addr;
		screen_pkg::pixel_row_t data;
	} write_t;

	logic clock25;
	logic arst_n;
	logic [31:0] ins_data;
	logic [31:0] mem_data;
	logic [31:0] reg_data;
	screen_pkg::probe_sel_t sel;
	screen_pkg::vram_addr_t vram_addr;
	screen_pkg::pixel_row_t vram_data;
	logic vram_write;

	logic [31:0] ins_table [NUM_ROWS];
	logic [31:0] mem_table [NUM_ROWS];
	logic [31:0] reg_table [NUM_ROWS];
	logic [63:0] font [16]; // Line 0 in the top byte
	int errs [1:NUM_TESTS];
	int cycle;
	int write_count;
	int run_len;
	int gap_len;
	int pass_count;
	int fail_count;
	bit done;
	screen_pkg::field_t last_field;
	screen_pkg::vram_addr_t prev_addr;

	char_engine #(
		.NUM_ROWS(NUM_ROWS)
	) char_engine_i (
		.clock25(clock25),
		.arst_n(arst_n),
		.ins_data(ins_data),
		.mem_data(mem_data),
		.reg_data(reg_data),
		.sel(sel),
		.vram_addr(vram_addr),
		.vram_data(vram_data),
		.vram_write(vram_write)
	);

	// CPU probes answer combinationally
	assign ins_data = ins_table[sel.ins_sel];
	assign mem_data = mem_table[sel.mem_sel];
	assign reg_data = reg_table[sel.reg_sel];

	always #(CLK_PERIOD / 2) clock25 = ~clock25;

	always @(posedge clock25) begin
		if (arst_n)
			cycle <= cycle + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int digits_in_field(input int f);
		case (f)
			0, 2, 4: return 2;
			default: return 8;
		endcase
	endfunction

	function automatic int column_of_field(input int f);
		case (f)
			0: return 2;
			1: return 11;
			2: return 21;
			3: return 30;
			4: return 40;
			default: return 49;
		endcase
	endfunction

	// Expected n-th write of the endless write stream
	function automatic write_t expected_write(input int n);
		int k;
		int row;
		int p;
		int line;
		int f;
		int width;
		logic [31:0] value;
		logic [3:0] digit;
		write_t w;
		k = n % WRITES_PER_FRAME;
		row = k / WRITES_PER_ROW;
		p = (k % WRITES_PER_ROW) / font_pkg::GLYPH_LINES;
		line = k % font_pkg::GLYPH_LINES;
		f = 0;
		while (p >= digits_in_field(f)) begin
			p = p - digits_in_field(f);
			f = f + 1;
		end
		case (f)
			1: value = ins_table[row];
			3: value = mem_table[row];
			5: value = reg_table[row];
			default: value = 32'(row);
		endcase
		width = digits_in_field(f);
		digit = value[4 * (width - 1 - p) +: 4]; // Most significant digit first
		w.field = screen_pkg::field_t'(f);
		w.addr = screen_pkg::vram_addr_t'(row * screen_pkg::ROW_STRIDE + column_of_field(f)
			+ p + line * screen_pkg::SCREEN_COLS);
		w.data = font[digit][63 - 8 * line -: 8];
		return w;
	endfunction

	task automatic compare_addr(input int test, input string what,
		input screen_pkg::vram_addr_t got, input screen_pkg::vram_addr_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s address 0x%04h, expected 0x%04h",
				$time, what, got, exp);
			errs[test]++;
		end
	endtask

	task automatic compare_pixels(input int test, input string what,
		input screen_pkg::pixel_row_t got, input screen_pkg::pixel_row_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s pixels %08b, expected %08b",
				$time, what, got, exp);
			errs[test]++;
		end
	endtask

	task automatic compare_sel(input int test, input string what,
		input screen_pkg::probe_sel_t got, input screen_pkg::probe_sel_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s selects %0d/%0d/%0d, expected %0d/%0d/%0d",
				$time, what, got.ins_sel, got.mem_sel, got.reg_sel,
				exp.ins_sel, exp.mem_sel, exp.reg_sel);
			errs[test]++;
		end
	endtask

	task automatic check_write(input int n);
		write_t exp;
		screen_pkg::probe_sel_t exp_sel;
		int test;
		int row;
		int cell_line;
		string what;
		exp = expected_write(n);
		row = (n % WRITES_PER_FRAME) / WRITES_PER_ROW;
		exp_sel.reg_sel = screen_pkg::row_index_t'(row);
		exp_sel.ins_sel = screen_pkg::row_index_t'(row);
		exp_sel.mem_sel = screen_pkg::row_index_t'(row);
		what = $sformatf("write %0d", n);
		if (n >= WRITES_PER_FRAME)
			test = 4; // Second frame must repeat the first
		else if (exp.field inside {screen_pkg::IDX_INS, screen_pkg::IDX_MEM, screen_pkg::IDX_REG})
			test = 2;
		else if (exp.field == screen_pkg::REG)
			test = 4;
		else
			test = 3;
		if (n == 0) begin
			if (cycle != FIRST_WRITE_CYCLE) begin
				$display("First write came in cycle %0d instead of cycle %0d",
					cycle, FIRST_WRITE_CYCLE);
				errs[1]++;
			end
			compare_addr(1, "first write", vram_addr, exp.addr);
			compare_pixels(1, "first write", vram_data, exp.data);
		end
		compare_addr(test, what, vram_addr, exp.addr);
		compare_pixels(test, what, vram_data, exp.data);
		// Selects still hold the field's row while line 0 goes out
		if (n % font_pkg::GLYPH_LINES == 0)
			compare_sel(test, what, sel, exp_sel);
		if (n % font_pkg::GLYPH_LINES != 0)
			compare_addr(5, {what, " line step"}, vram_addr,
				prev_addr + screen_pkg::vram_addr_t'(screen_pkg::SCREEN_COLS));
		cell_line = (int'(vram_addr) % screen_pkg::ROW_STRIDE) / screen_pkg::SCREEN_COLS;
		if (cell_line >= font_pkg::GLYPH_LINES) begin
			$display("MISMATCH at %0d ns: %s lands on cell line %0d", $time, what, cell_line);
			errs[5]++;
		end
		prev_addr = vram_addr;
		last_field = exp.field;
	endtask

	// Samples at the falling edge, away from register updates
	always @(negedge clock25) begin
		if (arst_n && !done) begin
			if (vram_write) begin
				if (gap_len != 0 && gap_len != 2) begin
					$display("MISMATCH at %0d ns: write gap of %0d cycles, expected 2",
						$time, gap_len);
					errs[5]++;
				end
				gap_len = 0;
				run_len++;
				check_write(write_count);
				write_count++;
				if (write_count == FRAMES * WRITES_PER_FRAME)
					done = 1'b1;
			end else begin
				if (write_count == 0 && cycle == FIRST_WRITE_CYCLE) begin
					$display("No write in cycle %0d after reset release", FIRST_WRITE_CYCLE);
					errs[1]++;
				end
				if (run_len != 0) begin
					if (run_len != 8 * digits_in_field(int'(last_field))) begin
						$display("MISMATCH at %0d ns: write run of %0d cycles, expected %0d",
							$time, run_len, 8 * digits_in_field(int'(last_field)));
						errs[5]++;
					end
					run_len = 0;
				end
				if (write_count > 0)
					gap_len++;
			end
		end
	end

	task automatic report_test(input int test, input string name);
		if (errs[test] == 0) begin
			pass_count++;
			$display("test %0d %s: ok", test, name);
		end else begin
			fail_count++;
			$display("test %0d %s: %0d errors", test, name, errs[test]);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the writes did not complete within %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	initial begin
		logic [31:0] rng;
		clock25 = 1'b0;
		arst_n = 1'b0;
		cycle = 0;
		write_count = 0;
		run_len = 0;
		gap_len = 0;
		pass_count = 0;
		fail_count = 0;
		done = 1'b0;
		last_field = screen_pkg::IDX_INS;
		prev_addr = '0;
		for (int t = 1; t <= NUM_TESTS; t++)
			errs[t] = 0;
		rng = 32'd80;
		for (int i = 0; i < NUM_ROWS; i++) begin
			rng = xorshift32(rng);
			ins_table[i] = rng;
			rng = xorshift32(rng);
			mem_table[i] = rng;
			rng = xorshift32(rng);
			reg_table[i] = rng;
		end
		font[0] = 64'h3C42_4242_4242_423C;
		font[1] = 64'h1838_7818_1818_187E;
		font[2] = 64'h3C66_660C_1830_607E;
		font[3] = 64'h7C06_067C_0606_067C;
		font[4] = 64'h0E16_2646_467E_0606;
		font[5] = 64'h7E60_6078_0C06_0C78;
		font[6] = 64'h3C40_407C_4242_423C;
		font[7] = 64'h7E06_0606_0C18_3060;
		font[8] = 64'h3C42_423C_4242_423C;
		font[9] = 64'h3C46_4646_3E06_0606;
		font[10] = 64'h3C42_4242_7E42_4242;
		font[11] = 64'h7C42_427C_4642_467C;
		font[12] = 64'h3E60_6060_6060_603E;
		font[13] = 64'h7C62_6262_6262_627C;
		font[14] = 64'h3E60_607E_6060_603E;
		font[15] = 64'h7E60_607E_6060_6060;
		repeat (RESET_CYCLES) @(posedge clock25);
		#1 arst_n = 1'b1;
		wait (write_count >= 1);
		report_test(1, "first write after reset");
		wait (write_count >= WRITES_PER_FRAME);
		report_test(2, "row index fields");
		report_test(3, "instruction and memory fields");
		wait (done);
		report_test(4, "register field and frame restart");
		report_test(5, "write bursts and gaps");
		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
